/* Bender.yml */
package:
  name: minimux

sources:
  - source/minimux_pkg.sv
  - source/mux_channel_map.sv
  - source/input_sync.sv
  - source/pin_debouncer.sv
  - source/quad_decoder.sv
  - source/event_queue.sv
  - source/minimux_core.sv
  - target: simulation
    files:
      - sim/tb_minimux.sv

/* flist.f */
source/minimux_pkg.sv
source/mux_channel_map.sv
source/input_sync.sv
source/pin_debouncer.sv
source/quad_decoder.sv
source/event_queue.sv
source/minimux_core.sv
sim/tb_minimux.sv

/* sim/tb_minimux.sv */
// Minimux core testbench
// Channel map sweep, encoder steps, errors and glitches, overload events
// and credit back-pressure, checked against a reference model

module tb_minimux
    import minimux_pkg::*;
();

    localparam int HOLD_CLKS  = 14;     // Debounce width 4 plus 10
    localparam int WAIT_LIMIT = 2000;   // Clocks per wait loop

    typedef struct packed {
        logic [N_SND-1:0] en_n;
        mux_drive_t       mux;
    } map_exp_t;

    logic               clk100;
    logic               pre_reset;
    logic [MUXCH_W-1:0] i_muxch;
    logic [N_ENC-1:0]   i_enc_pins;   // {n, b, a}
    logic [N_OVLD-1:0]  i_ovld;
    logic [DEB_W-1:0]   i_debounce_width;
    logic               i_credit_return;
    logic [N_SND-1:0]   o_en_snd_n;
    mux_drive_t         o_mux;
    logic               o_evt_valid;
    evt_word_u          o_evt_word;
    logic               o_overflow;
    logic [ERR_W-1:0]   o_err_count;

    // Reference model state
    logic [EVT_W-1:0]   exp_q [$];      // Words still to arrive
    logic [POS_W-1:0]   model_pos;
    logic [ERR_W-1:0]   model_err;
    logic [N_ENC-1:0]   model_pins;     // Last pin state seen
    logic [EVT_W-1:0]   model_word;
    logic [1:0]         gray_idx;       // Phase in the a/b sequence
    int                 rx_count = 0;
    int                 owed = 0;       // Credits not yet returned
    bit                 hold_credits = 0;
    integer             seed = 37488;

    minimux_core i_dut (
        .clk100, .pre_reset, .i_muxch, .i_enc_pins, .i_ovld,
        .i_debounce_width, .i_credit_return,
        .o_en_snd_n, .o_mux, .o_evt_valid, .o_evt_word, .o_overflow, .o_err_count
    );

    initial begin
        clk100 = 1'b0;
        forever #50 clk100 = ~clk100;
    end

    // ------------------------------
    // Reference functions
    // ------------------------------
    function automatic map_exp_t map_channel(input logic [MUXCH_W-1:0] ch);
        map_exp_t r;
        int       k;
        int       kn;
        r = '0;
        r.en_n = '1;
        k = ch % 32;
        kn = (k + 16) % 32;                 // Channel on the n side
        if (ch < 32) begin
            r.en_n[k] = 1'b0;
            if (k / 16 == 0) r.mux.p1 = {1'b1, 4'(k % 16)};
            else             r.mux.p2 = {1'b1, 4'(k % 16)};
            if (kn / 16 == 0) r.mux.n1 = {1'b1, 4'(kn % 16)};
            else              r.mux.n2 = {1'b1, 4'(kn % 16)};
        end
        return r;
    endfunction

    function automatic int seq_pos(input logic [1:0] ab);
        case (ab)                           // 00, 01, 11, 10
            2'b00:   return 0;
            2'b01:   return 1;
            2'b11:   return 2;
            default: return 3;
        endcase
    endfunction

    function automatic logic [EVT_W-1:0] enc_word_of(input enc_kind_t kind,
                                                     input logic [POS_W-1:0] pos);
        return {1'b0, kind, 5'd0, pos};
    endfunction

    function automatic logic [EVT_W-1:0] ovld_word_of(input logic [N_OVLD-1:0] vec,
                                                      input logic [MUXCH_W-1:0] ch);
        return {1'b1, 13'd0, vec, ch};
    endfunction

    // Steps the model on a new debounced pin state, 1 when a word results
    function automatic logic model_step(input logic [N_ENC-1:0] pins);
        logic [1:0] ab_old;
        logic [1:0] ab_new;
        logic       hit;
        ab_old = {model_pins[0], model_pins[1]};
        ab_new = {pins[0], pins[1]};
        hit = 1'b0;
        if (pins[2] && !model_pins[2]) begin     // Zero mark first
            model_pos  = '0;
            model_word = enc_word_of(zero, model_pos);
            hit = 1'b1;
        end else if ((ab_old ^ ab_new) == 2'b11) begin
            if (model_err != '1) model_err = model_err + 1'b1;
        end else if (ab_old != ab_new) begin
            if (seq_pos(ab_new) == (seq_pos(ab_old) + 1) % 4) begin
                model_pos  = model_pos + 1'b1;
                model_word = enc_word_of(inc, model_pos);
            end else begin
                model_pos  = model_pos - 1'b1;
                model_word = enc_word_of(dec, model_pos);
            end
            hit = 1'b1;
        end
        model_pins = pins;
        return hit;
    endfunction

    function automatic logic [N_ENC-1:0] make_pins(input logic [1:0] idx, input logic n);
        logic [1:0] ab;
        case (idx)
            2'd0:    ab = 2'b00;
            2'd1:    ab = 2'b01;
            2'd2:    ab = 2'b11;
            default: ab = 2'b10;
        endcase
        return {n, ab[0], ab[1]};
    endfunction

    // ------------------------------
    // Checks and helpers
    // ------------------------------
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("Error at time %0t: %s is %h, expected %h", $time, what, actual,
                     expected);
            $display("Test failures found");
            $fatal(1);
        end
    endtask

    task automatic next_slot();
        @(posedge clk100);
        #10;                                // Drive and sample point
    endtask

    task automatic drive_pins(input logic [N_ENC-1:0] pins, input bit expect_word);
        next_slot();
        i_enc_pins = pins;
        if (model_step(pins) && expect_word) exp_q.push_back(model_word);
        repeat (HOLD_CLKS) next_slot();
    endtask

    task automatic step_encoder(input bit up, input bit expect_word);
        gray_idx = up ? gray_idx + 2'd1 : gray_idx - 2'd1;
        drive_pins(make_pins(gray_idx, 1'b0), expect_word);
    endtask

    task automatic wait_until_drained();
        int cnt;
        cnt = 0;
        while ((exp_q.size() != 0 || owed != 0) && cnt < WAIT_LIMIT) begin
            next_slot();
            cnt++;
        end
        if (exp_q.size() != 0 || owed != 0) begin
            abort_run("Timed out waiting for event words and credit returns");
        end
        repeat (2) next_slot();             // Last credit absorbed
    endtask

    // Compare each delivered word with the queue head
    always @(negedge clk100) begin : monitor
        logic [EVT_W-1:0] expected;
        if (!pre_reset && o_evt_valid) begin
            if (exp_q.size() == 0) begin
                abort_run("An event word arrived when none was expected");
            end else begin
                expected = exp_q.pop_front();
                check_equal(o_evt_word, expected, "event word");
                rx_count++;
                owed++;
            end
        end
    end

    // One credit per clock while any are owed
    initial begin
        i_credit_return = 1'b0;
        forever begin
            next_slot();
            if (!hold_credits && owed > 0) begin
                i_credit_return = 1'b1;
                owed--;
            end else begin
                i_credit_return = 1'b0;
            end
        end
    end

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin : main
        int               rx_start;
        map_exp_t         exp_map;
        pre_reset        = 1'b1;
        i_muxch          = 6'h20;           // Idle
        i_enc_pins       = '0;
        i_ovld           = '0;
        i_debounce_width = 16'd4;
        model_pos        = '0;
        model_err        = '0;
        model_pins       = '0;
        gray_idx         = 2'd0;
        repeat (4) @(posedge clk100);
        #10 pre_reset = 1'b0;

        next_slot();                        // Reset state
        check_equal(o_evt_valid, 0, "evt_valid after reset");
        check_equal(o_overflow, 0, "overflow after reset");
        check_equal(o_en_snd_n, '1, "en_snd_n after reset");
        check_equal({o_mux.p1.en, o_mux.p2.en, o_mux.n1.en, o_mux.n2.en}, 0, "mux enables");
        check_equal(o_err_count, 0, "err_count after reset");

        for (int ch = 0; ch < 64; ch++) begin   // All channel numbers
            i_muxch = ch[MUXCH_W-1:0];
            next_slot();
            exp_map = map_channel(ch[MUXCH_W-1:0]);
            check_equal(o_en_snd_n, exp_map.en_n, $sformatf("en_snd_n, channel %0d", ch));
            check_equal(o_mux, exp_map.mux, $sformatf("mux drive, channel %0d", ch));
        end

        for (int s = 0; s < 40; s++) step_encoder($random(seed) & 1, 1'b1);
        drive_pins(make_pins(gray_idx, 1'b1), 1'b1);    // Zero mark
        drive_pins(make_pins(gray_idx, 1'b0), 1'b1);
        wait_until_drained();

        gray_idx  = gray_idx + 2'd2;        // Both bits at once
        drive_pins(make_pins(gray_idx, 1'b0), 1'b1);
        check_equal(o_err_count, model_err, "err_count after a/b jump");
        next_slot();                        // Glitch on a, 2 clocks
        i_enc_pins[0] = ~i_enc_pins[0];
        repeat (2) next_slot();
        i_enc_pins[0] = ~i_enc_pins[0];
        repeat (HOLD_CLKS) next_slot();
        step_encoder(1'b1, 1'b1);           // Decoding carries on
        wait_until_drained();

        i_muxch  = 6'd13;                   // Overload events
        repeat (3) next_slot();
        exp_q.push_back(ovld_word_of(4'b0101, 6'd13));
        i_ovld = 4'b0101;
        wait_until_drained();
        i_ovld = 4'b0000;                   // Back to zero, no word
        repeat (10) next_slot();
        i_muxch = 6'd27;
        repeat (3) next_slot();
        exp_q.push_back(ovld_word_of(4'b1000, 6'd27));
        i_ovld = 4'b1000;
        wait_until_drained();

        rx_start     = rx_count;            // Credits withheld
        hold_credits = 1'b1;
        check_equal(o_overflow, 0, "overflow before back-pressure");
        for (int s = 0; s < 10; s++) step_encoder(1'b1, s < 8);
        check_equal(rx_count - rx_start, 4, "words sent without credit return");
        check_equal(o_overflow, 1, "overflow with full queue");
        hold_credits = 1'b0;
        wait_until_drained();
        repeat (20) next_slot();            // Nothing more may arrive

        if (exp_q.size() != 0) begin
            abort_run("Some expected event words never arrived");
        end else begin
            $display("All tests passed!");
            $finish;
        end
    end

endmodule

/* source/event_queue.sv */
// Event queue
// Packs encoder and overload events into words, queues them and
// sends them against credits from the consumer

module event_queue
    import minimux_pkg::*;
(
    input  logic               clk100,
    input  logic               pre_reset,
    input  enc_pulse_t         i_pulse,
    input  logic [POS_W-1:0]   i_position,
    input  logic [N_OVLD-1:0]  i_ovld_sync,
    input  logic [MUXCH_W-1:0] i_muxch_q,
    input  logic               i_credit_return,
    output logic               o_evt_valid,
    output evt_word_u          o_evt_word,
    output logic               o_overflow
);

    logic [N_OVLD-1:0] ovld_q;       // Last overload vector
    logic              ovld_chg;     // Changed to nonzero
    logic              enc_any;
    logic              hold_valid;
    logic              hold_load;
    logic              hold_drop;    // Hold busy, event lost
    logic              push_valid;
    logic              do_push;
    logic              do_send;
    evt_word_u         enc_word;
    evt_word_u         ovld_word;
    evt_word_u         hold_word;
    evt_word_u         push_word;
    evt_word_u         mem [QUEUE_DEPTH];
    logic [QPTR_W-1:0] wr_ptr;
    logic [QPTR_W-1:0] rd_ptr;
    logic [QCNT_W-1:0] count;
    logic [CRED_W-1:0] credits;

    assign enc_any  = i_pulse.inc | i_pulse.dec | i_pulse.zero;
    assign ovld_chg = (i_ovld_sync != ovld_q) && (i_ovld_sync != '0);

    // ------------------------------
    // Word packing
    // ------------------------------
    always_comb begin
        enc_word              = '0;
        enc_word.enc.tag      = 1'b0;
        enc_word.enc.position = i_position;
        if (i_pulse.zero)     enc_word.enc.kind = zero;
        else if (i_pulse.dec) enc_word.enc.kind = dec;
        else                  enc_word.enc.kind = inc;

        ovld_word            = '0;
        ovld_word.ovld.tag   = 1'b1;
        ovld_word.ovld.vec   = i_ovld_sync;
        ovld_word.ovld.muxch = i_muxch_q;
    end

    // Encoder first, then the held overload, then a fresh one
    always_comb begin
        push_valid = 1'b1;
        push_word  = enc_word;
        if (!enc_any) begin
            if (hold_valid)     push_word = hold_word;
            else if (ovld_chg)  push_word = ovld_word;
            else                push_valid = 1'b0;
        end
    end

    // Park overload when the queue input is taken this clock
    assign hold_load = ovld_chg && (enc_any ? ~hold_valid : hold_valid);
    assign hold_drop = ovld_chg && enc_any && hold_valid;

    assign do_push = push_valid && (count != QCNT_W'(QUEUE_DEPTH));
    assign do_send = (count != '0) && (credits != '0);

    // ------------------------------
    // Control state
    // ------------------------------
    always_ff @(posedge clk100 or posedge pre_reset) begin
        if (pre_reset) begin
            ovld_q      <= '0;
            hold_valid  <= 1'b0;
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            credits     <= CRED_W'(CREDITS_INIT);
            o_evt_valid <= 1'b0;
            o_overflow  <= 1'b0;
        end else begin
            ovld_q      <= i_ovld_sync;
            o_evt_valid <= do_send;

            if (hold_load)     hold_valid <= 1'b1;
            else if (!enc_any) hold_valid <= 1'b0;   // Pushed this clock

            if (do_push) wr_ptr <= wr_ptr + 1'b1;    // Depth is a power of 2
            if (do_send) rd_ptr <= rd_ptr + 1'b1;

            case ({do_push, do_send})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase

            case ({do_send, i_credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase

            // Sticky until reset
            if ((push_valid && !do_push) || hold_drop) o_overflow <= 1'b1;
        end
    end

    // ------------------------------
    // Payload
    // ------------------------------
    always_ff @(posedge clk100) begin
        if (hold_load) hold_word <= ovld_word;
        if (do_push)   mem[wr_ptr] <= push_word;
        if (do_send)   o_evt_word <= mem[rd_ptr];
    end

endmodule

/* source/input_sync.sv */
// Input synchronizer
// Two flop stages for the encoder pins and the overload lines

module input_sync
    import minimux_pkg::*;
(
    input  logic              clk100,
    input  logic              pre_reset,
    input  logic [N_ENC-1:0]  i_enc_pins,
    input  logic [N_OVLD-1:0] i_ovld,
    output logic [N_ENC-1:0]  o_enc_sync,
    output logic [N_OVLD-1:0] o_ovld_sync
);

    localparam int N_LINES = N_ENC + N_OVLD;  // Seven lines

    logic [N_LINES-1:0] meta_q;   // First stage, may go metastable
    logic [N_LINES-1:0] sync_q;   // Second stage

    always_ff @(posedge clk100 or posedge pre_reset) begin
        if (pre_reset) begin
            meta_q <= '0;
            sync_q <= '0;
        end else begin
            meta_q <= {i_ovld, i_enc_pins};
            sync_q <= meta_q;
        end
    end

    // Split back into the two groups
    assign o_enc_sync  = sync_q[N_ENC-1:0];
    assign o_ovld_sync = sync_q[N_LINES-1:N_ENC];

endmodule

/* source/minimux_core.sv */
// Minimux sensing core
// Channel map, encoder path with debounce and decode, overload capture
// and the credit based event queue

module minimux_core
    import minimux_pkg::*;
(
    input  logic               clk100,
    input  logic               pre_reset,        // Async, active high
    input  logic [MUXCH_W-1:0] i_muxch,
    input  logic [N_ENC-1:0]   i_enc_pins,       // {n, b, a}
    input  logic [N_OVLD-1:0]  i_ovld,
    input  logic [DEB_W-1:0]   i_debounce_width,
    input  logic               i_credit_return,
    output logic [N_SND-1:0]   o_en_snd_n,
    output mux_drive_t         o_mux,
    output logic               o_evt_valid,
    output evt_word_u          o_evt_word,
    output logic               o_overflow,
    output logic [ERR_W-1:0]   o_err_count
);

    logic [MUXCH_W-1:0] muxch_q;
    logic [N_ENC-1:0]   enc_sync;
    logic [N_ENC-1:0]   enc_deb;
    logic [N_OVLD-1:0]  ovld_sync;
    enc_pulse_t         enc_pulse;
    logic [POS_W-1:0]   position;

    // ------------------------------
    // Channel map
    // ------------------------------
    mux_channel_map u_map (
        .clk100,
        .pre_reset,
        .i_muxch,
        .o_muxch_q  (muxch_q),
        .o_en_snd_n,
        .o_mux
    );

    // ------------------------------
    // Encoder path
    // ------------------------------
    input_sync u_sync (
        .clk100,
        .pre_reset,
        .i_enc_pins,
        .i_ovld,
        .o_enc_sync  (enc_sync),
        .o_ovld_sync (ovld_sync)
    );

    for (genvar i = 0; i < N_ENC; i++) begin : g_deb
        pin_debouncer u_deb (
            .clk100,
            .pre_reset,
            .i_width (i_debounce_width),
            .i_level (enc_sync[i]),
            .o_level (enc_deb[i])
        );
    end

    quad_decoder u_quad (
        .clk100,
        .pre_reset,
        .i_a         (enc_deb[0]),
        .i_b         (enc_deb[1]),
        .i_n         (enc_deb[2]),
        .o_pulse     (enc_pulse),
        .o_position  (position),
        .o_err_count
    );

    // ------------------------------
    // Events out
    // ------------------------------
    event_queue u_evq (
        .clk100,
        .pre_reset,
        .i_pulse     (enc_pulse),
        .i_position  (position),
        .i_ovld_sync (ovld_sync),
        .i_muxch_q   (muxch_q),
        .i_credit_return,
        .o_evt_valid,
        .o_evt_word,
        .o_overflow
    );

endmodule

/* source/minimux_pkg.sv */
// Minimux shared definitions
// Widths, queue sizing, mux drive structs and the event word layout

package minimux_pkg;

    // ------------------------------
    // Widths and sizes
    // ------------------------------
    localparam int N_SND        = 32;    // Sender channels
    localparam int MUXCH_W      = 6;     // Channel number, MSB = idle
    localparam int MUX_ADDR_W   = 4;     // Muxer address
    localparam int N_ENC        = 3;     // a, b, n
    localparam int N_OVLD       = 4;     // Overload lines
    localparam int DEB_W        = 16;    // Debounce width
    localparam int POS_W        = 16;    // Position counter
    localparam int ERR_W        = 8;     // Error counter
    localparam int QUEUE_DEPTH  = 4;
    localparam int CREDITS_INIT = 4;     // Credits after reset
    localparam int EVT_W        = 24;    // Event word

    localparam logic [MUXCH_W-1:0] MUXCH_IDLE = 6'h20; // Nothing selected

    // Derived sizes
    localparam int QPTR_W = $clog2(QUEUE_DEPTH);
    localparam int QCNT_W = $clog2(QUEUE_DEPTH + 1);
    localparam int CRED_W = $clog2(CREDITS_INIT + 1);

    // ------------------------------
    // Muxer drive
    // ------------------------------
    typedef struct packed {
        logic                  en;   // Muxer enable
        logic [MUX_ADDR_W-1:0] addr; // Input select
    } mux_sel_t;

    typedef struct packed {
        mux_sel_t p1;  // Positive, channels 0..15
        mux_sel_t p2;  // Positive, channels 16..31
        mux_sel_t n1;
        mux_sel_t n2;
    } mux_drive_t;

    // ------------------------------
    // Encoder
    // ------------------------------
    typedef enum logic [1:0] {
        inc  = 2'd0,
        dec  = 2'd1,
        zero = 2'd2
    } enc_kind_t;

    typedef struct packed {
        logic inc;   // One step up
        logic dec;   // One step down
        logic zero;  // Zero mark seen
    } enc_pulse_t;

    // ------------------------------
    // Event word, tag in bit 23
    // ------------------------------
    typedef struct packed {
        logic                           tag;  // 0
        enc_kind_t                      kind;
        logic [EVT_W-3-POS_W-1:0]       pad;
        logic [POS_W-1:0]               position;
    } evt_enc_t;

    typedef struct packed {
        logic                           tag;  // 1
        logic [EVT_W-1-N_OVLD-MUXCH_W-1:0] pad;
        logic [N_OVLD-1:0]              vec;   // New overload vector
        logic [MUXCH_W-1:0]             muxch; // Channel active at change
    } evt_ovld_t;

    typedef union packed {
        evt_enc_t  enc;
        evt_ovld_t ovld;
    } evt_word_u;

endpackage

/* source/mux_channel_map.sv */
// Mux channel map
// Registers the channel number and decodes sender enables and the
// four receive muxer selects

module mux_channel_map
    import minimux_pkg::*;
(
    input  logic               clk100,
    input  logic               pre_reset,
    input  logic [MUXCH_W-1:0] i_muxch,
    output logic [MUXCH_W-1:0] o_muxch_q,
    output logic [N_SND-1:0]   o_en_snd_n,
    output mux_drive_t         o_mux
);

    logic [MUXCH_W-1:0]       muxch_q;
    logic                     idle;
    logic [$clog2(N_SND)-1:0] snd_idx;   // Sender channel 0..31
    logic                     bank_p;    // 0 = p1, 1 = p2
    logic                     bank_n;    // Opposite half for n side

    // Channel register, idle after reset
    always_ff @(posedge clk100 or posedge pre_reset) begin
        if (pre_reset) begin
            muxch_q <= MUXCH_IDLE;
        end else begin
            muxch_q <= i_muxch;
        end
    end

    assign idle    = muxch_q[MUXCH_W-1];
    assign snd_idx = muxch_q[MUXCH_W-2:0];
    assign bank_p  = snd_idx[MUX_ADDR_W];
    assign bank_n  = ~snd_idx[MUX_ADDR_W];  // (k+16) mod 32

    // ------------------------------
    // Decode
    // ------------------------------
    always_comb begin
        o_en_snd_n = '1;    // Senders off (active low)
        o_mux      = '0;    // All muxers disabled
        if (!idle) begin
            o_en_snd_n[snd_idx] = 1'b0;
            if (bank_p) begin
                o_mux.p2.en   = 1'b1;
                o_mux.p2.addr = snd_idx[MUX_ADDR_W-1:0];
            end else begin
                o_mux.p1.en   = 1'b1;
                o_mux.p1.addr = snd_idx[MUX_ADDR_W-1:0];
            end
            // Same address in the other bank
            if (bank_n) begin
                o_mux.n2.en   = 1'b1;
                o_mux.n2.addr = snd_idx[MUX_ADDR_W-1:0];
            end else begin
                o_mux.n1.en   = 1'b1;
                o_mux.n1.addr = snd_idx[MUX_ADDR_W-1:0];
            end
        end
    end

    assign o_muxch_q = muxch_q;  // For overload events

endmodule

/* source/pin_debouncer.sv */
// Pin debouncer
// Output follows the input once it has been stable for more than
// i_width clocks

module pin_debouncer
    import minimux_pkg::*;
(
    input  logic             clk100,
    input  logic             pre_reset,
    input  logic [DEB_W-1:0] i_width,
    input  logic             i_level,
    output logic             o_level
);

    logic [DEB_W-1:0] stable_cnt;  // Clocks the input differs from output
    logic             level_q;

    // ------------------------------
    // Stability counter
    // ------------------------------
    always_ff @(posedge clk100 or posedge pre_reset) begin
        if (pre_reset) begin
            stable_cnt <= '0;
            level_q    <= 1'b0;
        end else begin
            if (i_level == level_q) begin
                stable_cnt <= '0;            // Glitch or no change, restart
            end else if (stable_cnt >= i_width) begin
                level_q    <= i_level;       // Held width+1 clocks
                stable_cnt <= '0;
            end else begin
                stable_cnt <= stable_cnt + 1'b1;
            end
        end
    end

    // Counter never passes i_width so no wrap

    assign o_level = level_q;

endmodule

/* source/quad_decoder.sv */
// Quadrature decoder
// Turns debounced a/b/n into step pulses, a wrapping position,
// a zero mark and a saturating error count

module quad_decoder
    import minimux_pkg::*;
(
    input  logic             clk100,
    input  logic             pre_reset,
    input  logic             i_a,
    input  logic             i_b,
    input  logic             i_n,
    output enc_pulse_t       o_pulse,
    output logic [POS_W-1:0] o_position,
    output logic [ERR_W-1:0] o_err_count
);

    logic             a_q;
    logic             b_q;
    logic             n_q;
    logic [1:0]       idx_now;    // Gray state as 0..3
    logic [1:0]       idx_prev;
    logic [1:0]       idx_diff;
    logic             step_up;
    logic             step_dn;
    logic             both_chg;   // a and b in one clock
    logic             n_rise;
    logic [POS_W-1:0] position;
    logic [ERR_W-1:0] err_cnt;

    // ------------------------------
    // State decode
    // ------------------------------
    // 00 -> 01 -> 11 -> 10 maps to 0 -> 1 -> 2 -> 3
    assign idx_now  = {i_a, i_a ^ i_b};
    assign idx_prev = {a_q, a_q ^ b_q};
    assign idx_diff = idx_now - idx_prev;

    assign step_up  = (idx_diff == 2'd1);
    assign step_dn  = (idx_diff == 2'd3);
    assign both_chg = (idx_diff == 2'd2);   // Illegal jump
    assign n_rise   = i_n & ~n_q;

    // ------------------------------
    // Counters and pulses
    // ------------------------------
    always_ff @(posedge clk100 or posedge pre_reset) begin
        if (pre_reset) begin
            a_q      <= 1'b0;
            b_q      <= 1'b0;
            n_q      <= 1'b0;
            position <= '0;
            err_cnt  <= '0;
            o_pulse  <= '0;
        end else begin
            a_q     <= i_a;
            b_q     <= i_b;
            n_q     <= i_n;
            o_pulse <= '0;                  // One clock only

            if (n_rise) begin               // Zero mark wins over a step
                position     <= '0;
                o_pulse.zero <= 1'b1;
            end else if (step_up) begin
                position    <= position + 1'b1;
                o_pulse.inc <= 1'b1;
            end else if (step_dn) begin
                position    <= position - 1'b1;
                o_pulse.dec <= 1'b1;
            end

            // Saturate at max
            if (both_chg && (err_cnt != '1)) begin
                err_cnt <= err_cnt + 1'b1;
            end
        end
    end

    assign o_position  = position;   // Already the updated value
    assign o_err_count = err_cnt;

endmodule
